//--- build.f
hw/timerPkg.sv
hw/ioCommandInterface.sv
hw/timerCell.sv
hw/fbiTimers.sv
verif/fbiTimersProperties.sv
verif/fbiTimersTb.sv

//--- Makefile
# Verilator flow for the timer bank testbench

VERILATOR ?= verilator
TOP       ?= fbiTimersTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The run passes only when the pass line shows up in the simulator output
run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verif/fbiTimersTb.sv
// Directed testbench that drives the timer bank's I/O port and checks its response channels
`timescale 1ns/1ns

module fbiTimersTb;
    import timerPkg::*;

    localparam int dataWidth = 16;
    localparam int ioTimeout = 20;
    localparam int waitMargin = 8;

    logic                        clk;
    logic                        rstN;
    logic                        clkEn;
    logic                        ioAck;
    logic                        ioReq;
    logic [3:0]                  minorOpcode;
    logic [dataWidth-1:0]        dataAddr;
    logic [dataWidth-1:0]        data;
    logic [timerCount-1:0]       timerAck;
    logic [timerCount-1:0]       timerReq;
    timerResp_t [timerCount-1:0] timerResp;

    int unsigned cycle = 0;

    fbiTimers #(
        .dataWidth(dataWidth)
    ) fbiTimers_i (
        .clk        (clk),
        .rstN       (rstN),
        .clkEn      (clkEn),
        .ioAck      (ioAck),
        .ioReq      (ioReq),
        .minorOpcode(minorOpcode),
        .dataAddr   (dataAddr),
        .data       (data),
        .timerAck   (timerAck),
        .timerReq   (timerReq),
        .timerResp  (timerResp)
    );

    initial begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    // Cycle index used to time Wait responses
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        if (actual !== expected) begin
            abortRun($sformatf("ERR %0t: %s is 0x%0h, expected 0x%0h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // Holds one beat on the port until ioReq lets it through
    task automatic driveBeat(input logic [dataWidth-1:0] beat, input logic store,
                             input logic [3:0] dest);
        int waited;
        logic [11:0] upperAddr;
        waited = 0;
        upperAddr = 12'($urandom());
        ioAck = 1'b1;
        data = beat;
        minorOpcode = {1'b0, store, 2'b00};
        dataAddr = {upperAddr, dest};
        while (!ioReq) begin
            if (waited == ioTimeout) begin
                abortRun("Timed out waiting for ioReq to take a command beat");
            end
            nextCycle();
            waited++;
        end
        nextCycle();
        ioAck = 1'b0;
    endtask

    // Sends the low half first and returns the cycle of the final beat in lastCycle
    task automatic sendCommand(input logic store, input logic op, input int sel,
                               input logic prescale, input int waitTime,
                               input logic [3:0] dest, output int unsigned lastCycle);
        timerCmd_t cmd;
        cmd.op = op;
        cmd.timerSel = 3'(sel);
        cmd.prescale = prescale;
        cmd.waitTime = 27'(waitTime);
        driveBeat(cmd[15:0], store, dest);
        driveBeat(cmd[31:16], store, dest);
        lastCycle = cycle;
    endtask

    task automatic waitForAck(input int sel, input int timeoutCycles);
        int waited;
        waited = 0;
        while (!timerAck[sel]) begin
            if (waited == timeoutCycles) begin
                abortRun($sformatf("Timed out after %0d cycles waiting for timer %0d to respond",
                                   timeoutCycles, sel));
            end
            nextCycle();
            waited++;
        end
    endtask

    task automatic expectResponse(input int sel, input logic [31:0] expData,
                                  input logic [3:0] expDest, input int timeoutCycles,
                                  input logic onlyChannel, output int unsigned ackCycle);
        waitForAck(sel, timeoutCycles);
        ackCycle = cycle;
        if (onlyChannel) begin
            checkValue(64'(timerAck), 64'(8'(1) << sel), "timerAck vector");
        end
        checkValue(64'(timerResp[sel].data), 64'(expData), $sformatf("timer %0d data", sel));
        checkValue(64'(timerResp[sel].destReg), 64'(expDest), $sformatf("timer %0d destReg", sel));
        timerReq[sel] = 1'b1;
        nextCycle();
        timerReq[sel] = 1'b0;
        checkValue(64'(timerAck[sel]), 64'(0), $sformatf("timer %0d ack after accept", sel));
    endtask

    task automatic testResetState();
        checkValue(64'(ioReq), 64'(1), "ioReq after reset");
        checkValue(64'(timerAck), 64'(0), "timerAck after reset");
    endtask

    task automatic testIdleCheck();
        logic [3:0] dest;
        int unsigned stamp;
        for (int i = 0; i < timerCount; i++) begin
            dest = 4'($urandom());
            sendCommand(1'b0, 1'b0, i, 1'b0, 0, dest, stamp);
            expectResponse(i, 32'd0, dest, 10, 1'b1, stamp);
        end
    endtask

    task automatic testSetCheckWait();
        int sel;
        int w;
        int unsigned setCycle;
        int unsigned ackCycle;
        int unsigned stamp;
        sel = int'($urandom_range(7));
        w = 20 + int'($urandom_range(80));
        sendCommand(1'b1, 1'b1, sel, 1'b0, w, 4'h0, setCycle);
        sendCommand(1'b0, 1'b0, sel, 1'b0, 0, 4'h3, stamp);
        expectResponse(sel, 32'd1, 4'h3, 10, 1'b1, stamp);
        sendCommand(1'b0, 1'b1, sel, 1'b0, 0, 4'h9, stamp);
        expectResponse(sel, 32'd0, 4'h9, w + waitMargin, 1'b1, ackCycle);
        if (ackCycle - setCycle < w || ackCycle - setCycle > w + waitMargin) begin
            abortRun($sformatf("ERR %0t: Wait on timer %0d took %0d cycles, wait time %0d",
                               $time, sel, ackCycle - setCycle, w));
        end
    endtask

    task automatic testPrescale();
        int sel;
        int w;
        int unsigned setCycle;
        int unsigned ackCycle;
        int unsigned stamp;
        sel = int'($urandom_range(7));
        w = 2 + int'($urandom_range(4));
        sendCommand(1'b1, 1'b1, sel, 1'b1, w, 4'h0, setCycle);
        sendCommand(1'b0, 1'b1, sel, 1'b0, 0, 4'hc, stamp);
        expectResponse(sel, 32'd0, 4'hc, 32 * w + waitMargin, 1'b1, ackCycle);
        if (ackCycle - setCycle < 32 * w) begin
            abortRun($sformatf("ERR %0t: Prescaled Wait on timer %0d took only %0d cycles",
                               $time, sel, ackCycle - setCycle));
        end
    endtask

    task automatic testClear();
        int sel;
        int unsigned stamp;
        sel = int'($urandom_range(7));
        sendCommand(1'b1, 1'b1, sel, 1'b0, 500, 4'h0, stamp);
        sendCommand(1'b1, 1'b0, sel, 1'b0, 0, 4'h0, stamp);
        sendCommand(1'b0, 1'b0, sel, 1'b0, 0, 4'h5, stamp);
        expectResponse(sel, 32'd0, 4'h5, 10, 1'b1, stamp);
        sendCommand(1'b0, 1'b1, sel, 1'b0, 0, 4'h6, stamp);
        expectResponse(sel, 32'd0, 4'h6, 4, 1'b1, stamp);
    endtask

    task automatic testBackPressure();
        int sel;
        int other;
        int unsigned stamp;
        timerResp_t held;
        sel = int'($urandom_range(7));
        other = (sel + 1 + int'($urandom_range(6))) % timerCount;
        sendCommand(1'b0, 1'b0, sel, 1'b0, 0, 4'ha, stamp);
        waitForAck(sel, 10);
        // Every earlier deadline has passed, so the Check answers 0
        held.data = 32'd0;
        held.destReg = 4'ha;
        // Second load sits in the port while the first response is held
        sendCommand(1'b0, 1'b0, sel, 1'b0, 0, 4'hb, stamp);
        repeat (6) begin
            checkValue(64'(ioReq), 64'(0), "ioReq with a load queued behind a held response");
            checkValue(64'(timerAck[sel]), 64'(1), "held timerAck");
            checkValue(64'(timerResp[sel]), 64'(held), "held response");
            nextCycle();
        end
        // First beat to another timer must not get through yet
        ioAck = 1'b1;
        data = '0;
        minorOpcode = 4'b0000;
        repeat (6) begin
            checkValue(64'(ioReq), 64'(0), "ioReq while a command to another timer waits");
            nextCycle();
        end
        ioAck = 1'b0;
        expectResponse(sel, 32'd0, 4'ha, 2, 1'b1, stamp);
        sendCommand(1'b0, 1'b0, other, 1'b0, 0, 4'h7, stamp);
        expectResponse(other, 32'd0, 4'h7, 10, 1'b0, stamp);
        expectResponse(sel, 32'd0, 4'hb, 10, 1'b0, stamp);
    endtask

    task automatic testCounterFreeze();
        int sel;
        int w;
        int unsigned stamp;
        sel = int'($urandom_range(7));
        w = 30;
        sendCommand(1'b1, 1'b1, sel, 1'b0, w, 4'h0, stamp);
        clkEn = 1'b0;
        sendCommand(1'b0, 1'b1, sel, 1'b0, 0, 4'h2, stamp);
        repeat (3 * w) begin
            nextCycle();
            checkValue(64'(timerAck[sel]), 64'(0), "timerAck while the counter is frozen");
        end
        clkEn = 1'b1;
        expectResponse(sel, 32'd0, 4'h2, w + waitMargin, 1'b1, stamp);
    endtask

    initial begin
        void'($urandom(32'h3015_8725));
        rstN = 1'b0;
        clkEn = 1'b1;
        ioAck = 1'b0;
        minorOpcode = '0;
        dataAddr = '0;
        data = '0;
        timerReq = '0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;
        nextCycle();
        testResetState();
        testIdleCheck();
        testSetCheckWait();
        testPrescale();
        testClear();
        testBackPressure();
        testCounterFreeze();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verif/fbiTimersProperties.sv
// Bound checks on reset state, response hold and the I/O ready line of the timer bank
`timescale 1ns/1ns

module fbiTimersProperties (
    input logic                                             clk,
    input logic                                             rstN,
    input logic                                             ioReq,
    input logic [timerPkg::timerCount-1:0]                  timerAck,
    input logic [timerPkg::timerCount-1:0]                  timerReq,
    input timerPkg::timerResp_t [timerPkg::timerCount-1:0]  timerResp
);
    import timerPkg::*;

    ackLowInReset: assert property (@(posedge clk) !rstN |-> timerAck == '0)
        else $error("timerAck raised during reset");

    ioReqKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(ioReq))
        else $error("ioReq is unknown after reset");

    // A response stays put until the outside takes it
    for (genvar i = 0; i < timerCount; i++) begin : genHold
        respHeld: assert property (@(posedge clk) disable iff (!rstN)
            timerAck[i] && !timerReq[i] |=> timerAck[i] && $stable(timerResp[i]))
            else $error("Response on timer %0d changed before it was accepted", i);
    end

endmodule

bind fbiTimers fbiTimersProperties fbiTimersProperties_i (
    .clk      (clk),
    .rstN     (rstN),
    .ioReq    (ioReq),
    .timerAck (timerAck),
    .timerReq (timerReq),
    .timerResp(timerResp)
);

//--- hw/fbiTimers.sv
// Bank of eight programmable cycle timers behind a narrow I/O command port
`timescale 1ns/1ns

module fbiTimers #(
    parameter int dataWidth = 16
) (
    input  logic                                             clk,
    input  logic                                             rstN,
    input  logic                                             clkEn,

    input  logic                                             ioAck,
    output logic                                             ioReq,
    input  logic [3:0]                                       minorOpcode,
    input  logic [dataWidth-1:0]                             dataAddr,
    input  logic [dataWidth-1:0]                             data,

    output logic [timerPkg::timerCount-1:0]                  timerAck,
    input  logic [timerPkg::timerCount-1:0]                  timerReq,
    output timerPkg::timerResp_t [timerPkg::timerCount-1:0]  timerResp
);
    import timerPkg::*;

    logic [31:0]           counter;

    logic                  cmdValid;
    logic                  cmdReady;
    timerCmd_t             cmd;
    logic                  cmdStore;
    logic [3:0]            destReg;

    logic [31:0]           scaledWait;
    cellReq_t              cellReq;
    logic [timerCount-1:0] cellValid;
    logic [timerCount-1:0] cellReady;

    ioCommandInterface #(
        .dataWidth(dataWidth)
    ) ioCommandInterface_i (
        .clk        (clk),
        .rstN       (rstN),
        .ioAck      (ioAck),
        .ioReq      (ioReq),
        .minorOpcode(minorOpcode),
        .dataAddr   (dataAddr),
        .data       (data),
        .cmdValid   (cmdValid),
        .cmdReady   (cmdReady),
        .cmd        (cmd),
        .cmdStore   (cmdStore),
        .destReg    (destReg)
    );

    // Free running cycle counter, frozen while clkEn is low
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            counter <= '0;
        end else if (clkEn) begin
            counter <= counter + 1'b1;
        end
    end

    // 32x prescale is a plain shift of the wait time
    assign scaledWait = cmd.prescale ? {cmd.waitTime, 5'd0} : {5'd0, cmd.waitTime};

    always_comb begin
        if (cmdStore) begin
            cellReq.op = cmd.op ? opSet : opClear;
        end else begin
            cellReq.op = cmd.op ? opWait : opCheck;
        end
        cellReq.deadline = counter + scaledWait;
        cellReq.destReg = destReg;
    end

    // Only the selected cell sees the strobe
    always_comb begin
        cellValid = '0;
        cellValid[cmd.timerSel] = cmdValid;
    end

    assign cmdReady = cellReady[cmd.timerSel];

    for (genvar i = 0; i < timerCount; i++) begin : genCell
        timerCell timerCell_i (
            .clk      (clk),
            .rstN     (rstN),
            .counter  (counter),
            .reqValid (cellValid[i]),
            .reqReady (cellReady[i]),
            .req      (cellReq),
            .timerAck (timerAck[i]),
            .timerReq (timerReq[i]),
            .timerResp(timerResp[i])
        );
    end

endmodule

//--- hw/timerCell.sv
// Single timer with deadline, armed flag and a load response channel
`timescale 1ns/1ns

module timerCell (
    input  logic                 clk,
    input  logic                 rstN,

    input  logic [31:0]          counter,

    input  logic                 reqValid,
    output logic                 reqReady,
    input  timerPkg::cellReq_t   req,

    output logic                 timerAck,
    input  logic                 timerReq,
    output timerPkg::timerResp_t timerResp
);
    import timerPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stWait,
        stResp
    } cellState_t;

    cellState_t  state;
    logic        armed;
    logic [31:0] deadline;
    logic [31:0] elapsed;
    logic        pending;
    logic        accept;
    logic        waitDone;
    logic        respBit;
    logic [3:0]  respDest;

    // Wrap-safe test, deadline passed once counter - deadline is not negative
    assign elapsed = counter - deadline;
    assign pending = armed && elapsed[31];

    // One load outstanding at most
    assign reqReady = (state == stIdle);
    assign accept = reqValid && reqReady;

    // Wait answers on the first cycle the timer is no longer pending
    assign waitDone = (state == stWait) && !pending;
    assign timerAck = (state == stResp) || waitDone;

    assign timerResp.data = {31'd0, respBit};
    assign timerResp.destReg = respDest;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            armed <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (accept) begin
                        unique case (req.op)
                            opClear: begin
                                armed <= 1'b0;
                            end
                            opSet: begin
                                armed <= 1'b1;
                            end
                            opCheck: begin
                                state <= stResp;
                            end
                            opWait: begin
                                state <= stWait;
                            end
                        endcase
                    end
                end
                stWait: begin
                    // Park in stResp so ack stays up until taken
                    if (waitDone) begin
                        state <= timerReq ? stIdle : stResp;
                    end
                end
                stResp: begin
                    if (timerReq) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Deadline and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            if (req.op == opSet) begin
                deadline <= req.deadline;
            end
            // Check reports pending, Wait always answers 0
            respBit <= (req.op == opCheck) && pending;
            respDest <= req.destReg;
        end
    end

endmodule

//--- hw/ioCommandInterface.sv
// Collects narrow I/O beats into a 32-bit timer command and holds it for the cells
`timescale 1ns/1ns

module ioCommandInterface #(
    parameter int dataWidth = 16
) (
    input  logic                 clk,
    input  logic                 rstN,

    input  logic                 ioAck,
    output logic                 ioReq,
    input  logic [3:0]           minorOpcode,
    input  logic [dataWidth-1:0] dataAddr,
    input  logic [dataWidth-1:0] data,

    output logic                 cmdValid,
    input  logic                 cmdReady,
    output timerPkg::timerCmd_t  cmd,
    output logic                 cmdStore,
    output logic [3:0]           destReg
);
    import timerPkg::*;

    localparam int beatCount = 32 / dataWidth;
    localparam int cntWidth = $clog2(beatCount + 1);
    localparam logic [cntWidth-1:0] lastBeat = cntWidth'(beatCount - 1);

    logic [cntWidth-1:0]   beatCnt;
    logic                  full;
    logic                  beatXfer;
    logic                  firstBeat;
    logic                  cmdTaken;
    logic [31:0]           asmWord;
    logic [dataWidth+31:0] shiftWide;

    assign beatXfer = ioAck && ioReq;
    assign cmdTaken = cmdValid && cmdReady;
    assign firstBeat = (beatCnt == '0);

    // Newest beat lands on top, so the low half ends up in bits 15:0
    assign shiftWide = {data, asmWord};

    // Port stalls while a complete command waits for its cell
    assign ioReq = !full;
    assign cmdValid = full;
    assign cmd = timerCmd_t'(asmWord);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            beatCnt <= '0;
            full <= 1'b0;
        end else begin
            if (beatXfer) begin
                if (beatCnt == lastBeat) begin
                    beatCnt <= '0;
                    full <= 1'b1;
                end else begin
                    beatCnt <= beatCnt + 1'b1;
                end
            end
            if (cmdTaken) begin
                full <= 1'b0;
            end
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (beatXfer) begin
            asmWord <= shiftWide[dataWidth+31:dataWidth];
        end
        // Opcode and destination only come with the first beat
        if (beatXfer && firstBeat) begin
            cmdStore <= minorOpcode[2];
            destReg <= dataAddr[3:0];
        end
    end

endmodule

//--- hw/timerPkg.sv
// Shared command, cell request and response types for the timer bank
package timerPkg;

    // Number of timer cells in the bank
    localparam int timerCount = 8;

    // Command word as seen on the I/O port, high bit first
    typedef struct packed {
        logic        op;
        logic [2:0]  timerSel;
        logic        prescale;
        logic [26:0] waitTime;
    } timerCmd_t;

    // Decoded operation, store ops first then loads
    typedef enum logic [1:0] {
        opClear,
        opSet,
        opCheck,
        opWait
    } timerOp_t;

    // One request broadcast to the cells
    typedef struct packed {
        timerOp_t    op;
        logic [31:0] deadline;
        logic [3:0]  destReg;
    } cellReq_t;

    // Load response on a cell's output channel
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  destReg;
    } timerResp_t;

endpackage
